// File: smem_cfg.svh
`ifndef SMEM_CFG_SVH
`define SMEM_CFG_SVH

// ------------------------------------------------------------
// engine limits
// ------------------------------------------------------------
`define SMEM_CL          512 // load and result line width
`define SMEM_READ_NUM_W  6
`define SMEM_MAX_READ    64  // reads per batch
`define SMEM_QUERY_MAX   64  // bases per query

// index side
`define SMEM_CNT_W       32
`define SMEM_INFLIGHT    4   // outstanding memory requests

`endif

// File: smem_idx_pkg.sv
`default_nettype none
`include "smem_cfg.svh"

package smem_idx_pkg;

	// 2-bit base code, same order as the L2 and occ fields
	typedef enum logic [1:0] {
		BASE_A,
		BASE_C,
		BASE_G,
		BASE_T
	} base_t;

	typedef logic [`SMEM_CNT_W-1:0] cnt_t; // count or interval bound

	// occurrences of each base before one BWT position
	typedef cnt_t [3:0] occ_set_t;

	// cumulative base counts, entry 0 for A
	typedef cnt_t [3:0] l2_table_t;

endpackage

`default_nettype wire

// File: smem_ctrl_pkg.sv
`default_nettype none
`include "smem_cfg.svh"

package smem_ctrl_pkg;

	typedef logic [`SMEM_READ_NUM_W-1:0] read_num_t;
	typedef logic [6:0] qpos_t; // 0 to 64

	// per-read progress in the queue
	typedef enum logic [1:0] {
		IDLE,  // not part of this batch
		READY, // may issue
		WAIT,  // request outstanding
		DONE
	} slot_state_t;

	typedef enum logic [1:0] {
		LOAD_PARAM,
		LOAD_READS,
		LOADED
	} load_state_t;

endpackage

`default_nettype wire

// File: smem_ext_if.sv
`default_nettype none

interface smem_ext_if;

	// step towards the datapath, one per memory response
	logic                     step_valid;
	smem_ctrl_pkg::read_num_t step_read_num;
	smem_ctrl_pkg::qpos_t     step_pos;
	smem_ctrl_pkg::qpos_t     step_len;
	smem_idx_pkg::base_t      step_base;
	smem_idx_pkg::cnt_t       step_occ_k; // count for step_base only
	smem_idx_pkg::cnt_t       step_occ_l;

	// writeback into the read slot
	logic                     wb_valid;
	smem_ctrl_pkg::read_num_t wb_read_num;
	smem_idx_pkg::cnt_t       wb_k;
	smem_idx_pkg::cnt_t       wb_l;
	smem_ctrl_pkg::qpos_t     wb_pos;
	logic                     wb_done;

	modport queue_mp (
		output step_valid, step_read_num, step_pos, step_len, step_base,
		output step_occ_k, step_occ_l,
		input  wb_valid, wb_read_num, wb_k, wb_l, wb_pos, wb_done
	);

	modport dp_mp (
		input  step_valid, step_read_num, step_pos, step_len, step_base,
		input  step_occ_k, step_occ_l,
		output wb_valid, wb_read_num, wb_k, wb_l, wb_pos, wb_done
	);

endinterface

`default_nettype wire

// File: read_ram.sv
`default_nettype none
`include "smem_cfg.svh"

module read_ram (
	input  wire                           clk_32ui_i,
	input  wire                           arst_n_i,
	input  wire                           load_valid_i,
	input  wire [`SMEM_CL-1:0]            load_data_i,
	input  wire [6:0]                     batch_size_i,
	input  wire                           batch_done_i,
	input  wire smem_ctrl_pkg::read_num_t base_read_num_i,
	input  wire smem_ctrl_pkg::qpos_t     base_pos_i,
	output smem_idx_pkg::base_t           base_o,
	output smem_ctrl_pkg::qpos_t          len_o,
	output smem_idx_pkg::l2_table_t       l2_o,
	output smem_idx_pkg::cnt_t            seq_len_o,
	output logic                          load_done_o
);

	smem_ctrl_pkg::load_state_t state_q;
	logic [6:0]                 load_cnt_q; // read lines taken so far
	logic                       last_line;

	// query store, two bits per base
	logic [2*`SMEM_QUERY_MAX-1:0] query_mem [`SMEM_MAX_READ];
	smem_ctrl_pkg::qpos_t         len_mem   [`SMEM_MAX_READ];
	smem_idx_pkg::cnt_t           seq_len_q;
	smem_idx_pkg::l2_table_t      l2_q;

	assign last_line = (load_cnt_q == batch_size_i - 7'd1);

	// ------------------------------------------------------------
	// load sequencing
	// ------------------------------------------------------------
	always_ff @(posedge clk_32ui_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= smem_ctrl_pkg::LOAD_PARAM;
			load_cnt_q <= '0;
		end else begin
			case (state_q)
				smem_ctrl_pkg::LOAD_PARAM: begin
					if (load_valid_i) begin
						state_q    <= smem_ctrl_pkg::LOAD_READS;
						load_cnt_q <= '0;
					end
				end
				smem_ctrl_pkg::LOAD_READS: begin
					if (load_valid_i) begin
						if (last_line)
							state_q <= smem_ctrl_pkg::LOADED;
						load_cnt_q <= load_cnt_q + 7'd1;
					end
				end
				smem_ctrl_pkg::LOADED: begin
					if (batch_done_i)
						state_q <= smem_ctrl_pkg::LOAD_PARAM; // next batch
				end
				default: state_q <= smem_ctrl_pkg::LOAD_PARAM;
			endcase
		end
	end

	// parameter line and query lines
	always_ff @(posedge clk_32ui_i) begin
		if (load_valid_i && state_q == smem_ctrl_pkg::LOAD_PARAM) begin
			seq_len_q <= load_data_i[31:0];
			l2_q      <= load_data_i[159:32]; // L2[0] sits right above seq_len
		end
		if (load_valid_i && state_q == smem_ctrl_pkg::LOAD_READS) begin
			query_mem[load_cnt_q[`SMEM_READ_NUM_W-1:0]] <= load_data_i[8 +: 2*`SMEM_QUERY_MAX];
			len_mem[load_cnt_q[`SMEM_READ_NUM_W-1:0]]   <= load_data_i[6:0];
		end
	end

	// base lookup for the queue
	assign base_o = smem_idx_pkg::base_t'(query_mem[base_read_num_i][{base_pos_i[5:0], 1'b0} +: 2]);
	assign len_o  = len_mem[base_read_num_i];

	assign l2_o        = l2_q;
	assign seq_len_o   = seq_len_q;
	assign load_done_o = (state_q == smem_ctrl_pkg::LOADED);

endmodule

`default_nettype wire

// File: read_queue.sv
`default_nettype none
`include "smem_cfg.svh"

module read_queue (
	input  wire                           clk_32ui_i,
	input  wire                           arst_n_i,
	input  wire                           load_done_i,
	input  wire [6:0]                     batch_size_i,
	input  wire smem_idx_pkg::cnt_t       seq_len_i,
	input  wire                           batch_done_i,

	// base lookup in read_ram
	output smem_ctrl_pkg::read_num_t      base_read_num_o,
	output smem_ctrl_pkg::qpos_t          base_pos_o,
	input  wire smem_idx_pkg::base_t      base_i,
	input  wire smem_ctrl_pkg::qpos_t     len_i,

	// memory port
	output logic                          dram_valid_o,
	output smem_idx_pkg::cnt_t            addr_k_o,
	output smem_idx_pkg::cnt_t            addr_l_o,
	output smem_ctrl_pkg::read_num_t      dram_read_num_o,
	input  wire                           dram_get_i,
	input  wire smem_idx_pkg::occ_set_t   occ_k_i,
	input  wire smem_idx_pkg::occ_set_t   occ_l_i,

	smem_ext_if.queue_mp                  ext
);

	localparam int unsigned FIFO_AW = $clog2(`SMEM_INFLIGHT);

	// per-read slots
	smem_ctrl_pkg::slot_state_t slot_st  [`SMEM_MAX_READ];
	smem_idx_pkg::cnt_t         slot_k   [`SMEM_MAX_READ];
	smem_idx_pkg::cnt_t         slot_l   [`SMEM_MAX_READ];
	smem_ctrl_pkg::qpos_t       slot_pos [`SMEM_MAX_READ];

	logic                     active_q;
	logic                     init;
	smem_ctrl_pkg::read_num_t issue_ptr_q; // rotating over the batch
	logic                     issue;
	logic                     ptr_wrap;

	// tags of outstanding requests, oldest at rd_ptr_q
	smem_ctrl_pkg::read_num_t tag_fifo [`SMEM_INFLIGHT];
	logic [FIFO_AW-1:0]       wr_ptr_q;
	logic [FIFO_AW-1:0]       rd_ptr_q;
	logic [FIFO_AW:0]         tag_cnt_q;
	logic                     fifo_full;
	smem_ctrl_pkg::read_num_t head_tag;

	assign init      = load_done_i && !active_q;
	assign fifo_full = (tag_cnt_q == `SMEM_INFLIGHT);
	assign issue     = active_q && !fifo_full && slot_st[issue_ptr_q] == smem_ctrl_pkg::READY;
	assign ptr_wrap  = ({1'b0, issue_ptr_q} == batch_size_i - 7'd1);
	assign head_tag  = tag_fifo[rd_ptr_q];

	assign dram_valid_o    = issue;
	assign dram_read_num_o = issue_ptr_q;
	assign addr_k_o        = slot_k[issue_ptr_q];
	assign addr_l_o        = slot_l[issue_ptr_q];

	// ------------------------------------------------------------
	// response pairing, step out in the dram_get cycle
	// ------------------------------------------------------------
	assign base_read_num_o = head_tag;
	assign base_pos_o      = slot_pos[head_tag];

	assign ext.step_valid    = dram_get_i;
	assign ext.step_read_num = head_tag;
	assign ext.step_pos      = slot_pos[head_tag];
	assign ext.step_len      = len_i;
	assign ext.step_base     = base_i;
	assign ext.step_occ_k    = occ_k_i[base_i]; // only the base we extend with
	assign ext.step_occ_l    = occ_l_i[base_i];

	always_ff @(posedge clk_32ui_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			active_q    <= 1'b0;
			issue_ptr_q <= '0;
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			tag_cnt_q   <= '0;
			for (int i = 0; i < `SMEM_MAX_READ; i++)
				slot_st[i] <= smem_ctrl_pkg::IDLE;
		end else begin
			if (batch_done_i)
				active_q <= 1'b0;
			else if (init)
				active_q <= 1'b1;

			if (init) begin
				issue_ptr_q <= '0;
				for (int i = 0; i < `SMEM_MAX_READ; i++)
					slot_st[i] <= (i < batch_size_i) ? smem_ctrl_pkg::READY : smem_ctrl_pkg::IDLE;
			end else begin
				// skip slots that cannot issue, hold on a full FIFO
				if (active_q && (issue || slot_st[issue_ptr_q] != smem_ctrl_pkg::READY))
					issue_ptr_q <= ptr_wrap ? '0 : issue_ptr_q + 1'b1;
				if (issue)
					slot_st[issue_ptr_q] <= smem_ctrl_pkg::WAIT;
				if (ext.wb_valid)
					slot_st[ext.wb_read_num] <= ext.wb_done ? smem_ctrl_pkg::DONE :
						smem_ctrl_pkg::READY;
			end

			if (issue)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (dram_get_i)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({issue, dram_get_i})
				2'b10:   tag_cnt_q <= tag_cnt_q + 1'b1;
				2'b01:   tag_cnt_q <= tag_cnt_q - 1'b1;
				default: tag_cnt_q <= tag_cnt_q;
			endcase
		end
	end

	// interval payload
	always_ff @(posedge clk_32ui_i) begin
		if (init) begin
			for (int i = 0; i < `SMEM_MAX_READ; i++) begin
				slot_k[i]   <= '0;
				slot_l[i]   <= seq_len_i; // whole text
				slot_pos[i] <= '0;
			end
		end else if (ext.wb_valid) begin
			slot_k[ext.wb_read_num]   <= ext.wb_k;
			slot_l[ext.wb_read_num]   <= ext.wb_l;
			slot_pos[ext.wb_read_num] <= ext.wb_pos;
		end
		if (issue)
			tag_fifo[wr_ptr_q] <= issue_ptr_q;
	end

endmodule

`default_nettype wire

// File: ext_datapath.sv
`default_nettype none

module ext_datapath (
	input  wire                          clk_32ui_i,
	input  wire                          arst_n_i,
	input  wire smem_idx_pkg::l2_table_t l2_i,
	smem_ext_if.dp_mp                    ext,
	output logic                         ret_valid_o,
	output smem_ctrl_pkg::qpos_t         ret_o,
	output smem_ctrl_pkg::read_num_t     ret_read_num_o
);

	smem_idx_pkg::cnt_t   k_next;
	smem_idx_pkg::cnt_t   l_next;
	smem_ctrl_pkg::qpos_t pos_inc;
	logic                 hit;  // interval still non-empty
	logic                 done;

	// ------------------------------------------------------------
	// forward extension by one base
	// ------------------------------------------------------------
	assign k_next  = l2_i[ext.step_base] + ext.step_occ_k;
	assign l_next  = l2_i[ext.step_base] + ext.step_occ_l;
	assign hit     = (k_next < l_next);
	assign pos_inc = ext.step_pos + 7'd1;
	assign done    = !hit || (pos_inc == ext.step_len); // mismatch or end of query

	always_ff @(posedge clk_32ui_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ext.wb_valid <= 1'b0;
			ret_valid_o  <= 1'b0;
		end else begin
			ext.wb_valid <= ext.step_valid;
			ret_valid_o  <= ext.step_valid && done;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (ext.step_valid) begin
			ext.wb_read_num <= ext.step_read_num;
			ext.wb_k        <= k_next;
			ext.wb_l        <= l_next;
			ext.wb_pos      <= hit ? pos_inc : ext.step_pos;
			ext.wb_done     <= done;
		end
	end

	// matched length is the written-back position
	assign ret_o          = ext.wb_pos;
	assign ret_read_num_o = ext.wb_read_num;

endmodule

`default_nettype wire

// File: result_out.sv
`default_nettype none
`include "smem_cfg.svh"

module result_out (
	input  wire                           clk_32ui_i,
	input  wire                           arst_n_i,
	input  wire [6:0]                     batch_size_i,
	input  wire                           ret_valid_i,
	input  wire smem_ctrl_pkg::qpos_t     ret_i,
	input  wire smem_ctrl_pkg::read_num_t ret_read_num_i,
	output logic                          batch_done_o,
	output logic                          output_request_o,
	input  wire                           output_permit_i,
	output logic [`SMEM_CL-1:0]           output_data_o,
	output logic                          output_valid_o,
	output logic                          output_finish_o
);

	smem_ctrl_pkg::qpos_t res_mem [`SMEM_MAX_READ]; // match length per read
	logic [`SMEM_CL-1:0]  line_next;
	logic [`SMEM_CL-1:0]  line_q;
	logic [6:0]           ret_cnt_q;
	logic                 req_q;
	logic                 fin_q;
	logic                 grant;

	assign grant = req_q && output_permit_i;

	// one byte per read, unused reads read as zero
	always_comb begin
		for (int i = 0; i < `SMEM_MAX_READ; i++)
			line_next[8*i +: 8] = (i < batch_size_i) ? {1'b0, res_mem[i]} : 8'd0;
	end

	// ------------------------------------------------------------
	// retirement count and request/permit
	// ------------------------------------------------------------
	always_ff @(posedge clk_32ui_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_q     <= 1'b0;
			fin_q     <= 1'b0;
			ret_cnt_q <= '0;
		end else begin
			fin_q <= grant; // single-cycle pulse
			if (grant) begin
				req_q     <= 1'b0;
				ret_cnt_q <= '0;
			end else if (ret_valid_i) begin
				if (ret_cnt_q == batch_size_i - 7'd1)
					req_q <= 1'b1; // last read of the batch
				ret_cnt_q <= ret_cnt_q + 7'd1;
			end
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (ret_valid_i)
			res_mem[ret_read_num_i] <= ret_i;
		if (grant)
			line_q <= line_next;
	end

	assign output_request_o = req_q;
	assign output_data_o    = line_q;
	assign output_valid_o   = fin_q;
	assign output_finish_o  = fin_q;
	assign batch_done_o     = fin_q;

endmodule

`default_nettype wire

// File: smem_top.sv
`default_nettype none
`include "smem_cfg.svh"

module smem_top (
	input  wire                         clk_32ui_i,
	input  wire                         arst_n_i,

	// read loading
	input  wire                         load_valid_i,
	input  wire [`SMEM_CL-1:0]          load_data_i,
	input  wire [6:0]                   batch_size_i,
	output logic                        read_load_done_o,

	// memory requests and responses
	output logic                        dram_valid_o,
	output smem_idx_pkg::cnt_t          addr_k_o,
	output smem_idx_pkg::cnt_t          addr_l_o,
	output smem_ctrl_pkg::read_num_t    dram_read_num_o,
	input  wire                         dram_get_i,
	input  wire smem_idx_pkg::occ_set_t occ_k_i,
	input  wire smem_idx_pkg::occ_set_t occ_l_i,

	// result line
	output logic                        output_request_o,
	input  wire                         output_permit_i,
	output logic [`SMEM_CL-1:0]         output_data_o,
	output logic                        output_valid_o,
	output logic                        output_finish_o
);

	smem_ctrl_pkg::read_num_t base_read_num;
	smem_ctrl_pkg::qpos_t     base_pos;
	smem_idx_pkg::base_t      base;
	smem_ctrl_pkg::qpos_t     len;
	smem_idx_pkg::l2_table_t  l2;
	smem_idx_pkg::cnt_t       seq_len;
	logic                     batch_done; // with the finish pulse
	logic                     ret_valid;
	smem_ctrl_pkg::qpos_t     ret;
	smem_ctrl_pkg::read_num_t ret_read_num;

	smem_ext_if ext_if ();

	read_ram read_ram0 (
		.clk_32ui_i      (clk_32ui_i),
		.arst_n_i        (arst_n_i),
		.load_valid_i    (load_valid_i),
		.load_data_i     (load_data_i),
		.batch_size_i    (batch_size_i),
		.batch_done_i    (batch_done),
		.base_read_num_i (base_read_num),
		.base_pos_i      (base_pos),
		.base_o          (base),
		.len_o           (len),
		.l2_o            (l2),
		.seq_len_o       (seq_len),
		.load_done_o     (read_load_done_o)
	);

	read_queue read_queue0 (
		.clk_32ui_i      (clk_32ui_i),
		.arst_n_i        (arst_n_i),
		.load_done_i     (read_load_done_o),
		.batch_size_i    (batch_size_i),
		.seq_len_i       (seq_len),
		.batch_done_i    (batch_done),
		.base_read_num_o (base_read_num),
		.base_pos_o      (base_pos),
		.base_i          (base),
		.len_i           (len),
		.dram_valid_o    (dram_valid_o),
		.addr_k_o        (addr_k_o),
		.addr_l_o        (addr_l_o),
		.dram_read_num_o (dram_read_num_o),
		.dram_get_i      (dram_get_i),
		.occ_k_i         (occ_k_i),
		.occ_l_i         (occ_l_i),
		.ext             (ext_if.queue_mp)
	);

	ext_datapath ext_datapath0 (
		.clk_32ui_i     (clk_32ui_i),
		.arst_n_i       (arst_n_i),
		.l2_i           (l2),
		.ext            (ext_if.dp_mp),
		.ret_valid_o    (ret_valid),
		.ret_o          (ret),
		.ret_read_num_o (ret_read_num)
	);

	result_out result_out0 (
		.clk_32ui_i       (clk_32ui_i),
		.arst_n_i         (arst_n_i),
		.batch_size_i     (batch_size_i),
		.ret_valid_i      (ret_valid),
		.ret_i            (ret),
		.ret_read_num_i   (ret_read_num),
		.batch_done_o     (batch_done),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_data_o    (output_data_o),
		.output_valid_o   (output_valid_o),
		.output_finish_o  (output_finish_o)
	);

endmodule

`default_nettype wire

// File: smem_checker.sv
`default_nettype none
`include "smem_cfg.svh"

module smem_checker #(
	parameter int TEXT_MAX = 256
) (
	input  wire                         clk_32ui_i,
	input  wire                         arst_n_i,
	input  wire                         load_valid_i,
	input  wire [`SMEM_CL-1:0]          load_data_i,
	input  wire [6:0]                   batch_size_i,
	input  wire                         read_load_done_i,
	input  wire                         dram_valid_i,
	input  wire [`SMEM_READ_NUM_W-1:0]  dram_read_num_i,
	input  wire                         dram_get_i,
	input  wire                         output_request_i,
	input  wire                         output_valid_i,
	input  wire                         output_finish_i,
	input  wire [`SMEM_CL-1:0]          output_data_i,
	input  wire [2*TEXT_MAX-1:0]        text_i,
	output int unsigned                 err_cnt_o,
	output int unsigned                 line_cnt_o
);

	logic [`SMEM_CL-1:0] param_q;                  // seq_len and L2
	logic [`SMEM_CL-1:0] read_q [`SMEM_MAX_READ];
	int unsigned         loaded;
	logic                in_param;  // next load line is a parameter line
	logic                loading;
	logic                done_due;  // load done expected this cycle
	logic                line_seen;
	logic                req_prev;  // request level at the previous edge
	int                  outstanding;
	int unsigned         exp_len;

	// occurrences of base c in text[0 .. a-1]
	function automatic int unsigned occ_ref(input logic [1:0] c, input int unsigned a);
		int unsigned n;
		n = 0;
		for (int i = 0; i < a; i++)
			if (text_i[2*i +: 2] == c)
				n++;
		return n;
	endfunction

	// bases matched before the interval runs empty or the query ends
	function automatic int unsigned expect_len(input logic [`SMEM_CL-1:0] line);
		int unsigned k;
		int unsigned l;
		int unsigned nk;
		int unsigned nl;
		int unsigned l2c;
		int unsigned len;
		int unsigned pos;
		logic [1:0]  c;
		k   = 0;
		l   = param_q[31:0];
		len = line[6:0];
		pos = 0;
		while (pos < len) begin
			c   = line[8 + 2*pos +: 2];
			l2c = param_q[32 + 32*c +: 32];
			nk  = l2c + occ_ref(c, k);
			nl  = l2c + occ_ref(c, l);
			if (nk >= nl)
				return pos;
			k = nk;
			l = nl;
			pos++;
		end
		return len;
	endfunction

	initial begin
		err_cnt_o  = 0;
		line_cnt_o = 0;
	end

	always @(posedge clk_32ui_i) begin
		if (!arst_n_i) begin
			in_param    = 1'b1;
			loading     = 1'b0;
			done_due    = 1'b0;
			line_seen   = 1'b0;
			req_prev    = 1'b0;
			loaded      = 0;
			outstanding = 0;
			if (dram_valid_i || read_load_done_i || output_request_i ||
				output_valid_i || output_finish_i) begin
				$display("error at %0t: control output high during reset", $time);
				err_cnt_o++;
			end
		end else begin
			// ------------------------------------------------------------
			// load sequence
			// ------------------------------------------------------------
			if (done_due && read_load_done_i !== 1'b1) begin
				$display("error at %0t: load done did not rise after the last read line", $time);
				err_cnt_o++;
			end
			if (loading && read_load_done_i) begin
				$display("error at %0t: load done high before the batch was loaded", $time);
				err_cnt_o++;
			end
			done_due = 1'b0;
			if (load_valid_i && in_param) begin
				param_q   = load_data_i;
				in_param  = 1'b0;
				loading   = 1'b1;
				loaded    = 0;
				line_seen = 1'b0;
			end else if (load_valid_i && loading) begin
				read_q[loaded] = load_data_i;
				loaded++;
				if (loaded == batch_size_i) begin
					loading  = 1'b0;
					done_due = 1'b1;
				end
			end

			// memory request limits
			if (dram_valid_i && dram_read_num_i >= batch_size_i) begin
				$display("error at %0t: request for read %0d outside the batch",
					$time, dram_read_num_i);
				err_cnt_o++;
			end
			outstanding = outstanding + int'(dram_valid_i) - int'(dram_get_i);
			if (outstanding > `SMEM_INFLIGHT) begin
				$display("error at %0t: %0d memory requests outstanding", $time, outstanding);
				err_cnt_o++;
			end

			// ------------------------------------------------------------
			// result line
			// ------------------------------------------------------------
			if (output_valid_i && !req_prev) begin
				$display("error at %0t: result line without a pending output request", $time);
				err_cnt_o++;
			end
			if (req_prev && !output_request_i && !output_valid_i) begin
				$display("error at %0t: output request dropped before the result line", $time);
				err_cnt_o++;
			end
			req_prev = output_request_i;
			if (output_valid_i != output_finish_i) begin
				$display("error at %0t: output valid and finish pulses differ", $time);
				err_cnt_o++;
			end
			if (output_valid_i) begin
				line_cnt_o++;
				if (line_seen) begin
					$display("error at %0t: second result line for one batch", $time);
					err_cnt_o++;
				end
				line_seen = 1'b1;
				for (int i = 0; i < `SMEM_MAX_READ; i++) begin
					exp_len = (i < batch_size_i) ? expect_len(read_q[i]) : 0;
					if (output_data_i[8*i +: 8] !== exp_len) begin
						$display("mismatch at %0t: read %0d match length %0d, expected %0d",
							$time, i, output_data_i[8*i +: 8], exp_len);
						err_cnt_o++;
					end
				end
				in_param = 1'b1; // engine back to parameter load
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_smem.sv
`default_nettype none
`include "smem_cfg.svh"

module tb_smem;

	localparam int TEXT_MAX    = 256;   // longest BWT text
	localparam int DRIVE_DLY   = 2;
	// two batches of up to 24 reads, 64 steps each, with margin
	localparam int TIMEOUT_CYC = 40000;

	logic                     clk_32ui;
	logic                     arst_n;
	logic                     load_valid;
	logic [`SMEM_CL-1:0]      load_data;
	logic [6:0]               batch_size;
	logic                     read_load_done;
	logic                     dram_valid;
	smem_idx_pkg::cnt_t       addr_k;
	smem_idx_pkg::cnt_t       addr_l;
	smem_ctrl_pkg::read_num_t dram_read_num;
	logic                     dram_get;
	smem_idx_pkg::occ_set_t   occ_k;
	smem_idx_pkg::occ_set_t   occ_l;
	logic                     output_request;
	logic                     output_permit;
	logic [`SMEM_CL-1:0]      output_data;
	logic                     output_valid;
	logic                     output_finish;

	logic [2*TEXT_MAX-1:0]    text; // base i at bits 2i+1:2i
	int unsigned              text_len;
	int unsigned              cycle_cnt = 0;
	int unsigned              chk_err;
	int unsigned              chk_lines;
	int unsigned              total_err;
	smem_idx_pkg::cnt_t       req_k_q [$]; // outstanding requests, oldest first
	smem_idx_pkg::cnt_t       req_l_q [$];

	initial clk_32ui = 1'b0;
	always #20 clk_32ui = ~clk_32ui;

	smem_top dut0 (
		.clk_32ui_i       (clk_32ui),
		.arst_n_i         (arst_n),
		.load_valid_i     (load_valid),
		.load_data_i      (load_data),
		.batch_size_i     (batch_size),
		.read_load_done_o (read_load_done),
		.dram_valid_o     (dram_valid),
		.addr_k_o         (addr_k),
		.addr_l_o         (addr_l),
		.dram_read_num_o  (dram_read_num),
		.dram_get_i       (dram_get),
		.occ_k_i          (occ_k),
		.occ_l_i          (occ_l),
		.output_request_o (output_request),
		.output_permit_i  (output_permit),
		.output_data_o    (output_data),
		.output_valid_o   (output_valid),
		.output_finish_o  (output_finish)
	);

	smem_checker #(.TEXT_MAX(TEXT_MAX)) chk0 (
		.clk_32ui_i       (clk_32ui),
		.arst_n_i         (arst_n),
		.load_valid_i     (load_valid),
		.load_data_i      (load_data),
		.batch_size_i     (batch_size),
		.read_load_done_i (read_load_done),
		.dram_valid_i     (dram_valid),
		.dram_read_num_i  (dram_read_num),
		.dram_get_i       (dram_get),
		.output_request_i (output_request),
		.output_valid_i   (output_valid),
		.output_finish_i  (output_finish),
		.output_data_i    (output_data),
		.text_i           (text),
		.err_cnt_o        (chk_err),
		.line_cnt_o       (chk_lines)
	);

	// occurrences of each base in text[0 .. a-1]
	function automatic smem_idx_pkg::occ_set_t occ_at(input smem_idx_pkg::cnt_t a);
		smem_idx_pkg::occ_set_t o;
		o = '0;
		for (int i = 0; i < a; i++)
			o[text[2*i +: 2]] = o[text[2*i +: 2]] + 1;
		return o;
	endfunction

	function automatic logic [`SMEM_CL-1:0] param_line();
		logic [`SMEM_CL-1:0]    line;
		smem_idx_pkg::occ_set_t tot;
		smem_idx_pkg::cnt_t     acc;
		line       = '0;
		tot        = occ_at(text_len);
		acc        = '0;
		line[31:0] = text_len;
		for (int c = 0; c < 4; c++) begin
			line[32 + 32*c +: 32] = acc; // bases sorting below c
			acc = acc + tot[c];
		end
		return line;
	endfunction

	function automatic logic [`SMEM_CL-1:0] random_read(input int unsigned len);
		logic [`SMEM_CL-1:0] line;
		line      = '0;
		line[6:0] = len;
		for (int i = 0; i < len; i++)
			line[8 + 2*i +: 2] = $urandom_range(3, 0);
		return line;
	endfunction

	// follows the LF mapping from a random row, so every prefix stays in the index
	function automatic logic [`SMEM_CL-1:0] indexed_read(input int unsigned len);
		logic [`SMEM_CL-1:0]     line;
		smem_idx_pkg::l2_table_t l2;
		smem_idx_pkg::occ_set_t  occ;
		logic [1:0]              c;
		int unsigned             row;
		line      = param_line();
		l2        = line[159:32];
		line      = '0;
		line[6:0] = len;
		row       = $urandom_range(text_len - 1, 0);
		for (int i = 0; i < len; i++) begin
			c   = text[2*row +: 2];
			occ = occ_at(row);
			line[8 + 2*i +: 2] = c;
			row = l2[c] + occ[c];
		end
		return line;
	endfunction

	// ------------------------------------------------------------
	// memory model, answers in request order
	// ------------------------------------------------------------
	task automatic serve_memory();
		int unsigned delay;
		delay = 0;
		forever begin
			@(posedge clk_32ui);
			if (dram_valid) begin
				req_k_q.push_back(addr_k);
				req_l_q.push_back(addr_l);
			end
			#DRIVE_DLY;
			dram_get = 1'b0;
			if (req_k_q.size() > 0) begin
				if (delay == 0)
					delay = $urandom_range(8, 1);
				delay = delay - 1;
				if (delay == 0) begin
					dram_get = 1'b1;
					occ_k    = occ_at(req_k_q.pop_front());
					occ_l    = occ_at(req_l_q.pop_front());
				end
			end
		end
	endtask

	// new text, parameter line, then n read lines; odd reads come from the index
	task automatic load_batch(input int unsigned n, input int unsigned txt_n);
		text     = '0;
		text_len = txt_n;
		for (int i = 0; i < txt_n; i++)
			text[2*i +: 2] = $urandom_range(3, 0);
		batch_size = n;
		load_valid = 1'b1;
		load_data  = param_line();
		@(posedge clk_32ui);
		#DRIVE_DLY;
		for (int r = 0; r < n; r++) begin
			if (r % 2)
				load_data = indexed_read($urandom_range(64, 1));
			else
				load_data = random_read($urandom_range(64, 1));
			@(posedge clk_32ui);
			#DRIVE_DLY;
		end
		load_valid = 1'b0;
	endtask

	task automatic drain_batch();
		@(posedge clk_32ui);
		while (!output_request)
			@(posedge clk_32ui);
		repeat ($urandom_range(12, 0)) @(posedge clk_32ui); // late permit
		#DRIVE_DLY;
		output_permit = 1'b1;
		@(posedge clk_32ui);
		while (!output_finish)
			@(posedge clk_32ui);
		#DRIVE_DLY;
		output_permit = 1'b0;
	endtask

	always @(posedge clk_32ui) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("timeout: run stopped after %0d cycles, %0d errors so far",
				cycle_cnt, chk_err);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h7ecc_3072));
		arst_n        = 1'b0;
		load_valid    = 1'b0;
		load_data     = '0;
		batch_size    = '0;
		dram_get      = 1'b0;
		occ_k         = '0;
		occ_l         = '0;
		output_permit = 1'b0;
		text          = '0;
		text_len      = 0;
		fork
			serve_memory();
		join_none
		repeat (4) @(posedge clk_32ui);
		#DRIVE_DLY;
		arst_n = 1'b1;
		@(posedge clk_32ui);
		#DRIVE_DLY;
		load_batch(16, 200);
		drain_batch();
		load_batch(24, $urandom_range(250, 120)); // new text and L2
		drain_batch();
		repeat (4) @(posedge clk_32ui);
		total_err = chk_err + ((chk_lines != 2) ? 1 : 0);
		if (chk_lines != 2)
			$display("error: %0d result lines seen where 2 were expected", chk_lines);
		$display("errors: %0d total, %0d from checker, %0d result lines",
			total_err, chk_err, chk_lines);
		if (total_err == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
smem_idx_pkg.sv
smem_ctrl_pkg.sv
smem_ext_if.sv
read_ram.sv
read_queue.sv
ext_datapath.sv
result_out.sv
smem_top.sv
smem_checker.sv
tb_smem.sv
